// File: logic/miner_pkg.sv
// game-side item types; item x is 9 bits and y 8 bits, so items sit inside a 512x256 area
package miner_pkg;

    // store depth and index
    localparam int ITEM_SLOTS = 16;
    typedef logic [3:0] item_idx_t;

    typedef enum logic [1:0] {
        KIND_STONE   = 2'd0,
        KIND_GOLD    = 2'd1,
        KIND_DIAMOND = 2'd2
    } item_kind_t;

    // one item slot as stored
    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        item_kind_t kind;
        logic       visible;
        logic       dragged;
    } item_t;

    // load port payload
    typedef struct packed {
        item_idx_t index;
        item_t     item;
    } item_load_t;

    localparam logic [7:0] POINTS_STONE   = 8'd1;
    localparam logic [7:0] POINTS_GOLD    = 8'd2;
    localparam logic [7:0] POINTS_DIAMOND = 8'd5;

    // score wraps at 1024
    typedef logic [9:0] score_t;

endpackage

// File: logic/geom_pkg.sv
// rope geometry types; length keeps 8 fraction bits and trig magnitudes are scaled by 256
package geom_pkg;

    typedef logic [7:0]  angle_t;
    typedef logic [9:0]  coord_t;
    typedef logic [17:0] rope_len_t;

    // cosine sign is kept apart, sine is never negative over 0..180
    typedef struct packed {
        logic [8:0] sin_mag;
        logic [8:0] cos_mag;
        logic       cos_neg;
    } trig_t;

    localparam coord_t ROPE_MIN   = 10'd20;
    localparam coord_t ROPE_MAX   = 10'd275;
    localparam angle_t ANGLE_LOW  = 8'd15;
    localparam angle_t ANGLE_HIGH = 8'd165;
    localparam int     FIELD_W    = 320;
    localparam int     FIELD_H    = 240;

endpackage

// File: logic/go_key_pulse.sv
// go key is synchronised only, not debounced; a bouncing key can raise extra requests
`timescale 1ns/1ps

module go_key_pulse (
    input  logic clock,
    input  logic resetn,
    input  logic go_key,
    input  logic go_taken,
    output logic go_request
);
    logic sync_a;
    logic sync_b;
    logic key_q;
    logic pending;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            sync_a  <= 1'b0;
            sync_b  <= 1'b0;
            key_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            sync_a <= go_key;
            sync_b <= sync_a;
            key_q  <= sync_b;
            // a new press wins over a take in the same cycle
            if (sync_b && !key_q) begin
                pending <= 1'b1;
            end else if (go_taken) begin
                pending <= 1'b0;
            end
        end
    end

    assign go_request = pending;

endmodule

// File: logic/trig_rom.sv
// table covers whole degrees 0 to 180 only; other angles return the 90 degree entry
`timescale 1ns/1ps

module trig_rom import geom_pkg::*; (
    input  angle_t angle,
    output trig_t  trig
);
    localparam real PI = 3.14159265358979;

    trig_t  table_w [0:180];
    angle_t idx;

    // entries rounded to the nearest 1/256
    for (genvar d = 0; d <= 180; d++) begin : g_deg
        localparam real RAD     = d * PI / 180.0;
        localparam real COS_ABS = (d > 90) ? -$cos(RAD) : $cos(RAD);
        localparam int  SIN_Q   = $rtoi($sin(RAD) * 256.0 + 0.5);
        localparam int  COS_Q   = $rtoi(COS_ABS * 256.0 + 0.5);

        assign table_w[d] = '{
            sin_mag: 9'(SIN_Q),
            cos_mag: 9'(COS_Q),
            cos_neg: (d > 90)
        };
    end

    assign idx  = (angle > 8'd180) ? 8'd90 : angle;
    assign trig = table_w[idx];

endmodule

// File: logic/item_store.sv
// single-port item store; draw reads own the port, rope access only gets free cycles
`timescale 1ns/1ps

module item_store import miner_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  item_load_t load_data,
    input  logic       load_valid,
    output logic       load_ready,
    input  logic       load_enable,
    input  item_idx_t  draw_index,
    input  logic       draw_valid,
    output logic       draw_ready,
    output item_t      draw_item,
    output logic       draw_item_valid,
    output logic       draw_busy,
    input  item_idx_t  rope_index,
    input  logic       rope_write,
    input  item_t      rope_wdata,
    output item_t      rope_rdata
);
    item_t     mem [ITEM_SLOTS];
    item_t     rd_q;
    item_idx_t addr;
    logic      ready_q;
    logic      load_go;
    logic      rope_sel;

    assign draw_busy  = draw_valid;
    assign draw_ready = ready_q;
    assign load_ready = load_enable && !draw_valid;
    assign load_go    = load_valid && load_ready;
    assign rope_sel   = !draw_valid && !(load_enable && load_valid);

    // port owner: draw, then load, then rope
    always_comb begin
        if (draw_valid) begin
            addr = draw_index;
        end else if (load_enable && load_valid) begin
            addr = load_data.index;
        end else begin
            addr = rope_index;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            ready_q         <= 1'b0;
            draw_item_valid <= 1'b0;
            for (int i = 0; i < ITEM_SLOTS; i++) begin
                mem[i].visible <= 1'b0;
            end
        end else begin
            ready_q         <= 1'b1;
            draw_item_valid <= draw_valid && draw_ready;
            if (load_go) begin
                mem[load_data.index] <= load_data.item;
            end else if (rope_sel && rope_write) begin
                mem[rope_index] <= rope_wdata;
            end
        end
        rd_q <= mem[addr];
    end

    // one read register shared by both readers
    assign draw_item  = rd_q;
    assign rope_rdata = rd_q;

endmodule

// File: logic/rope_swing_ctrl.sv
// rope FSM; a held draw request freezes frame counting and every store access
`timescale 1ns/1ps

module rope_swing_ctrl import miner_pkg::*, geom_pkg::*; #(
    parameter int FRAME_TICKS = 4,
    parameter int DRAG_FRAMES = 3,
    parameter int DELTA_LEN   = 6,
    parameter int ORIGIN_X    = 160,
    parameter int ORIGIN_Y    = 45
) (
    input  logic       clock,
    input  logic       resetn,
    input  logic       enable,
    input  logic       go_request,
    output logic       go_taken,
    input  logic       draw_busy,
    input  logic [4:0] item_count,
    input  trig_t      trig,
    output angle_t     angle,
    output coord_t     end_x,
    output coord_t     end_y,
    output coord_t     rope_len,
    output item_idx_t  rope_index,
    output logic       rope_write,
    output item_t      rope_wdata,
    input  item_t      rope_rdata,
    output logic       collect_valid,
    output item_kind_t collect_kind,
    output logic       idle
);
    localparam rope_len_t   LEN_MIN   = rope_len_t'(ROPE_MIN * 256);
    localparam rope_len_t   LEN_STEP  = rope_len_t'(DELTA_LEN * 256);
    localparam rope_len_t   LEN_FLOOR = rope_len_t'((ROPE_MIN + DELTA_LEN) * 256);
    localparam logic [31:0] TGT_FRAME = 32'(FRAME_TICKS);
    localparam logic [31:0] TGT_RET   = 32'(2 * FRAME_TICKS);
    localparam logic [31:0] TGT_DRAG  = 32'((2 + DRAG_FRAMES) * FRAME_TICKS);

    typedef enum logic [3:0] {
        ST_STOP,
        ST_SWING_WAIT,
        ST_SWING_STEP,
        ST_EXT_WAIT,
        ST_EXT_STEP,
        ST_SCAN,
        ST_RET_WAIT,
        ST_RET_STEP,
        ST_DRAG_WRITE,
        ST_COLLECT
    } state_t;

    state_t             state;
    rope_len_t          length;
    logic [31:0]        frame_cnt;
    logic [31:0]        wait_tgt;
    logic               wait_done;
    logic               dir_up;
    logic               loaded;
    logic               drag_moving;
    logic               at_min;
    logic               out_of_field;
    logic               slot_hit;
    logic [1:0]         scan_phase;
    logic [4:0]         scan_idx;
    item_idx_t          drag_idx;
    item_t              drag_item;
    item_t              cur_item;
    logic [18:0]        prod_x;
    logic [18:0]        prod_y;
    logic signed [11:0] dx;
    logic signed [11:0] dy;
    logic signed [11:0] x_s;
    logic signed [11:0] y_s;
    logic [10:0]        ex;
    logic [10:0]        ey;
    logic [10:0]        ix;
    logic [10:0]        iy;

    // hook end from length and angle, x may go below zero
    assign rope_len = length[17:8];
    assign prod_x   = rope_len * trig.cos_mag;
    assign prod_y   = rope_len * trig.sin_mag;
    assign dx       = {1'b0, prod_x[18:8]};
    assign dy       = {1'b0, prod_y[18:8]};
    assign x_s      = trig.cos_neg ? 12'(ORIGIN_X) - dx : 12'(ORIGIN_X) + dx;
    assign y_s      = 12'(ORIGIN_Y) + dy;
    assign end_x    = x_s[9:0];
    assign end_y    = y_s[9:0];

    assign at_min       = rope_len <= ROPE_MIN;
    assign out_of_field = x_s <= 12'sd10 || x_s >= 12'(FIELD_W - 10)
                       || y_s >= 12'(FIELD_H - 10) || rope_len >= ROPE_MAX;

    // item box is x..x+16 wide and y-6..y+16 high
    assign ex       = {1'b0, end_x};
    assign ey       = {1'b0, end_y};
    assign ix       = {2'b0, cur_item.x};
    assign iy       = {3'b0, cur_item.y};
    assign slot_hit = cur_item.visible && !cur_item.dragged
                   && ex >= ix && ex <= ix + 11'd16
                   && ey + 11'd6 >= iy && ey <= iy + 11'd16;

    // the step cycle itself counts toward the frame
    always_comb begin
        if (state == ST_RET_WAIT) begin
            wait_tgt = loaded ? TGT_DRAG : TGT_RET;
        end else begin
            wait_tgt = TGT_FRAME;
        end
    end
    assign wait_done = !draw_busy && (frame_cnt + 32'd2 >= wait_tgt);

    assign go_taken      = (state == ST_SWING_STEP) && go_request;
    assign rope_write    = state == ST_DRAG_WRITE;
    assign rope_index    = rope_write ? drag_idx : scan_idx[3:0];
    assign collect_valid = state == ST_COLLECT;
    assign collect_kind  = drag_item.kind;
    assign idle          = state == ST_STOP;

    // the item follows the hook, and vanishes once the hook is home
    always_comb begin
        rope_wdata = drag_item;
        if (drag_moving) begin
            rope_wdata.x       = end_x[8:0];
            rope_wdata.y       = end_y[7:0];
            rope_wdata.visible = !at_min;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state       <= ST_STOP;
            angle       <= 8'd90;
            length      <= LEN_MIN;
            frame_cnt   <= 32'd0;
            dir_up      <= 1'b0;
            loaded      <= 1'b0;
            drag_moving <= 1'b0;
            scan_phase  <= 2'd0;
            scan_idx    <= 5'd0;
        end else begin
            case (state)
                ST_STOP: begin
                    angle     <= 8'd90;
                    length    <= LEN_MIN;
                    dir_up    <= 1'b0;
                    loaded    <= 1'b0;
                    frame_cnt <= 32'd0;
                    if (enable) begin
                        state <= ST_SWING_WAIT;
                    end
                end
                ST_SWING_WAIT: begin
                    if (!enable) begin
                        state <= ST_STOP;
                    end else if (wait_done) begin
                        frame_cnt <= 32'd0;
                        state     <= ST_SWING_STEP;
                    end else if (!draw_busy) begin
                        frame_cnt <= frame_cnt + 32'd1;
                    end
                end
                ST_SWING_STEP: begin
                    if (dir_up) begin
                        angle <= angle + 8'd1;
                        if (angle + 8'd1 >= ANGLE_HIGH) begin
                            dir_up <= 1'b0;
                        end
                    end else begin
                        angle <= angle - 8'd1;
                        if (angle - 8'd1 <= ANGLE_LOW) begin
                            dir_up <= 1'b1;
                        end
                    end
                    state <= go_request ? ST_EXT_WAIT : ST_SWING_WAIT;
                end
                ST_EXT_WAIT: begin
                    if (wait_done) begin
                        frame_cnt <= 32'd0;
                        state     <= ST_EXT_STEP;
                    end else if (!draw_busy) begin
                        frame_cnt <= frame_cnt + 32'd1;
                    end
                end
                ST_EXT_STEP: begin
                    length     <= length + LEN_STEP;
                    scan_idx   <= 5'd0;
                    scan_phase <= 2'd0;
                    state      <= ST_SCAN;
                end
                ST_SCAN: begin
                    // address, data back, compare
                    case (scan_phase)
                        2'd0: begin
                            if (scan_idx >= item_count) begin
                                state <= out_of_field ? ST_RET_WAIT : ST_EXT_WAIT;
                            end else if (!draw_busy) begin
                                scan_phase <= 2'd1;
                            end
                        end
                        2'd1: begin
                            cur_item   <= rope_rdata;
                            scan_phase <= 2'd2;
                        end
                        default: begin
                            scan_phase <= 2'd0;
                            if (slot_hit) begin
                                drag_idx          <= scan_idx[3:0];
                                drag_item         <= cur_item;
                                drag_item.dragged <= 1'b1;
                                loaded            <= 1'b1;
                                drag_moving       <= 1'b0;
                                state             <= ST_DRAG_WRITE;
                            end else begin
                                scan_idx <= scan_idx + 5'd1;
                            end
                        end
                    endcase
                end
                ST_RET_WAIT: begin
                    if (wait_done) begin
                        frame_cnt <= 32'd0;
                        state     <= ST_RET_STEP;
                    end else if (!draw_busy) begin
                        frame_cnt <= frame_cnt + 32'd1;
                    end
                end
                ST_RET_STEP: begin
                    length <= (length <= LEN_FLOOR) ? LEN_MIN : length - LEN_STEP;
                    if (loaded) begin
                        drag_moving <= 1'b1;
                        state       <= ST_DRAG_WRITE;
                    end else if (length <= LEN_FLOOR) begin
                        state <= ST_SWING_WAIT;
                    end else begin
                        state <= ST_RET_WAIT;
                    end
                end
                ST_DRAG_WRITE: begin
                    if (!draw_busy) begin
                        state <= (drag_moving && at_min) ? ST_COLLECT : ST_RET_WAIT;
                    end
                end
                ST_COLLECT: begin
                    // swing resumes in the direction it had before the shot
                    loaded      <= 1'b0;
                    drag_moving <= 1'b0;
                    state       <= ST_SWING_WAIT;
                end
                default: begin
                    state <= ST_STOP;
                end
            endcase
        end
    end

endmodule

// File: logic/score_tally.sv
// score is 10 bits and wraps; an unknown kind scores as stone
`timescale 1ns/1ps

module score_tally import miner_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  logic       collect_valid,
    input  item_kind_t collect_kind,
    output score_t     score,
    output logic       collect_pulse,
    output item_kind_t collect_kind_out
);
    logic [7:0] points;

    always_comb begin
        case (collect_kind)
            KIND_GOLD:    points = POINTS_GOLD;
            KIND_DIAMOND: points = POINTS_DIAMOND;
            default:      points = POINTS_STONE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            score         <= '0;
            collect_pulse <= 1'b0;
        end else begin
            collect_pulse <= collect_valid;
            if (collect_valid) begin
                score <= score + score_t'(points);
            end
        end
    end

    // kind travels alongside the pulse
    always_ff @(posedge clock) begin
        collect_kind_out <= collect_kind;
    end

endmodule

// File: logic/miner_rope_top.sv
// loads are accepted only while play is stopped; draw requests stall the rope while held
`timescale 1ns/1ps

module miner_rope_top import miner_pkg::*, geom_pkg::*; #(
    parameter int FRAME_TICKS = 4,
    parameter int DRAG_FRAMES = 3,
    parameter int DELTA_LEN   = 6,
    parameter int ORIGIN_X    = 160,
    parameter int ORIGIN_Y    = 45
) (
    input  logic       clock,
    input  logic       resetn,
    input  logic       enable,
    input  logic       go_key,
    input  item_load_t load_data,
    input  logic       load_valid,
    output logic       load_ready,
    input  logic [4:0] item_count,
    input  item_idx_t  draw_index,
    input  logic       draw_valid,
    output logic       draw_ready,
    output item_t      draw_item,
    output logic       draw_item_valid,
    output angle_t     angle,
    output coord_t     end_x,
    output coord_t     end_y,
    output coord_t     rope_len,
    output score_t     score,
    output logic       collect_pulse,
    output item_kind_t collect_kind
);
    logic       go_request;
    logic       go_taken;
    logic       draw_busy;
    logic       idle;
    trig_t      trig;
    item_idx_t  rope_index;
    logic       rope_write;
    item_t      rope_wdata;
    item_t      rope_rdata;
    logic       collect_valid;
    item_kind_t ctrl_kind;

    go_key_pulse u_go (
        .clock      (clock),
        .resetn     (resetn),
        .go_key     (go_key),
        .go_taken   (go_taken),
        .go_request (go_request)
    );

    rope_swing_ctrl #(
        .FRAME_TICKS (FRAME_TICKS),
        .DRAG_FRAMES (DRAG_FRAMES),
        .DELTA_LEN   (DELTA_LEN),
        .ORIGIN_X    (ORIGIN_X),
        .ORIGIN_Y    (ORIGIN_Y)
    ) u_ctrl (
        .clock         (clock),
        .resetn        (resetn),
        .enable        (enable),
        .go_request    (go_request),
        .go_taken      (go_taken),
        .draw_busy     (draw_busy),
        .item_count    (item_count),
        .trig          (trig),
        .angle         (angle),
        .end_x         (end_x),
        .end_y         (end_y),
        .rope_len      (rope_len),
        .rope_index    (rope_index),
        .rope_write    (rope_write),
        .rope_wdata    (rope_wdata),
        .rope_rdata    (rope_rdata),
        .collect_valid (collect_valid),
        .collect_kind  (ctrl_kind),
        .idle          (idle)
    );

    trig_rom u_trig (
        .angle (angle),
        .trig  (trig)
    );

    item_store u_store (
        .clock           (clock),
        .resetn          (resetn),
        .load_data       (load_data),
        .load_valid      (load_valid),
        .load_ready      (load_ready),
        .load_enable     (idle),
        .draw_index      (draw_index),
        .draw_valid      (draw_valid),
        .draw_ready      (draw_ready),
        .draw_item       (draw_item),
        .draw_item_valid (draw_item_valid),
        .draw_busy       (draw_busy),
        .rope_index      (rope_index),
        .rope_write      (rope_write),
        .rope_wdata      (rope_wdata),
        .rope_rdata      (rope_rdata)
    );

    score_tally u_score (
        .clock            (clock),
        .resetn           (resetn),
        .collect_valid    (collect_valid),
        .collect_kind     (ctrl_kind),
        .score            (score),
        .collect_pulse    (collect_pulse),
        .collect_kind_out (collect_kind)
    );

endmodule

// File: verif/rope_tb.sv
// runs the shot schedule twice, the second time with random draw stalls; assumes FRAME_TICKS 4 and origin 160,45
`timescale 1ns/1ps

module rope_tb import miner_pkg::*, geom_pkg::*; ();
    localparam int FRAME_TICKS = 4;
    localparam int DRAG_FRAMES = 3;
    localparam int DELTA_LEN   = 6;
    localparam int ORIGIN_X    = 160;
    localparam int ORIGIN_Y    = 45;
    localparam int STEPS       = ROPE_MAX / DELTA_LEN + 1;
    // extend with full scans, loaded retract, and a full swing to reach the press angle
    localparam int SHOT_CYCLES = STEPS * (FRAME_TICKS + 3 * ITEM_SLOTS + 2)
                               + STEPS * (2 + DRAG_FRAMES) * FRAME_TICKS
                               + 300 * FRAME_TICKS;
    localparam int NO_HIT      = 99;

    logic       clock = 1'b0;
    logic       resetn;
    logic       enable;
    logic       go_key;
    item_load_t load_data;
    logic       load_valid;
    logic       load_ready;
    logic [4:0] item_count;
    item_idx_t  draw_index;
    logic       draw_valid;
    logic       draw_ready;
    item_t      draw_item;
    logic       draw_item_valid;
    angle_t     angle;
    coord_t     end_x;
    coord_t     end_y;
    coord_t     rope_len;
    score_t     score;
    logic       collect_pulse;
    item_kind_t collect_kind;

    item_load_t loads[$];
    int         shot_angle[$];
    int         shot_slot[$];
    int         shot_score[$];
    item_t      expected_mem [ITEM_SLOTS];
    logic       moved [ITEM_SLOTS];
    logic       in_use [ITEM_SLOTS];
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         pulse_count;
    item_kind_t pulse_kind;
    int         error_count = 0;
    int         last_angle;
    bit         angle_track;
    bit         stall_on;
    bit         reading;

    miner_rope_top #(
        .FRAME_TICKS (FRAME_TICKS),
        .DRAG_FRAMES (DRAG_FRAMES),
        .DELTA_LEN   (DELTA_LEN),
        .ORIGIN_X    (ORIGIN_X),
        .ORIGIN_Y    (ORIGIN_Y)
    ) uut (
        .clock           (clock),
        .resetn          (resetn),
        .enable          (enable),
        .go_key          (go_key),
        .load_data       (load_data),
        .load_valid      (load_valid),
        .load_ready      (load_ready),
        .item_count      (item_count),
        .draw_index      (draw_index),
        .draw_valid      (draw_valid),
        .draw_ready      (draw_ready),
        .draw_item       (draw_item),
        .draw_item_valid (draw_item_valid),
        .angle           (angle),
        .end_x           (end_x),
        .end_y           (end_y),
        .rope_len        (rope_len),
        .score           (score),
        .collect_pulse   (collect_pulse),
        .collect_kind    (collect_kind)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one falling edge with pulse counting, play checks and random draw stalls
    task automatic tick();
        int diff;
        @(negedge clock);
        if (collect_pulse) begin
            pulse_count++;
            pulse_kind = collect_kind;
        end
        if (angle_track) begin
            diff = int'(angle) - last_angle;
            check_value("angle_in_range", (angle >= ANGLE_LOW && angle <= ANGLE_HIGH), 1);
            check_value("angle_step", (diff >= -1 && diff <= 1), 1);
            // hook end lies within rope reach below the origin
            check_value("end_x_reach",
                        (end_x + rope_len >= ORIGIN_X && end_x <= ORIGIN_X + rope_len), 1);
            check_value("end_y_reach",
                        (end_y >= ORIGIN_Y && end_y <= ORIGIN_Y + rope_len), 1);
            check_value("load_ready_in_play", load_ready, 0);
        end
        last_angle = angle;
        if (stall_on && !reading) begin
            draw_valid = ($urandom_range(0, 7) == 0);
            draw_index = item_idx_t'($urandom_range(0, ITEM_SLOTS - 1));
        end
    endtask

    // response is due exactly one cycle after the request
    task automatic read_slot(input int idx, output item_t got);
        reading    = 1'b1;
        draw_index = item_idx_t'(idx);
        draw_valid = 1'b1;
        tick();
        draw_valid = 1'b0;
        check_value("draw_item_valid", draw_item_valid, 1);
        got     = draw_item;
        reading = 1'b0;
    endtask

    task automatic load_item(input item_load_t ld);
        load_data  = ld;
        load_valid = 1'b1;
        while (!load_ready) begin
            tick();
        end
        tick();
        load_valid = 1'b0;
    endtask

    // moved items only keep their visible bit predictable
    task automatic compare_slots();
        item_t got;
        for (int i = 0; i < ITEM_SLOTS; i++) begin
            if (in_use[i]) begin
                read_slot(i, got);
                if (moved[i]) begin
                    check_value($sformatf("slot%0d_visible", i), got.visible, 0);
                end else begin
                    check_value($sformatf("slot%0d_record", i), got, expected_mem[i]);
                end
            end
        end
    endtask

    task automatic run_shot(input int k);
        int    start;
        int    slot;
        item_t got;
        slot = shot_slot[k];
        while (angle != angle_t'(shot_angle[k])) begin
            tick();
        end
        go_key = 1'b1;
        repeat (3) tick();
        go_key = 1'b0;
        start = pulse_count;
        while (rope_len == ROPE_MIN) begin
            tick();
        end
        while (rope_len != ROPE_MIN) begin
            tick();
        end
        if (slot != NO_HIT) begin
            while (pulse_count == start) begin
                tick();
            end
            check_value("collect_kind", pulse_kind, expected_mem[slot].kind);
        end
        repeat (2 * FRAME_TICKS) tick();
        check_value("collect_pulse_count", pulse_count - start, (slot != NO_HIT) ? 1 : 0);
        check_value("score", score, shot_score[k]);
        if (slot != NO_HIT) begin
            expected_mem[slot].visible = 1'b0;
            moved[slot] = 1'b1;
            read_slot(slot, got);
            check_value("hit_slot_visible", got.visible, 0);
        end else begin
            compare_slots();
        end
    endtask

    task automatic run_pass(input bit stalls);
        stall_on    = 1'b0;
        reading     = 1'b0;
        angle_track = 1'b0;
        enable      = 1'b0;
        go_key      = 1'b0;
        load_valid  = 1'b0;
        draw_valid  = 1'b0;
        resetn      = 1'b0;
        repeat (16) tick();
        check_value("draw_ready_in_reset", draw_ready, 0);
        resetn = 1'b1;
        tick();
        check_value("score", score, 0);
        check_value("angle", angle, 90);
        check_value("rope_len", rope_len, ROPE_MIN);
        // rope at rest hangs straight down from the origin
        check_value("end_x", end_x, ORIGIN_X);
        check_value("end_y", end_y, ORIGIN_Y + ROPE_MIN);
        check_value("collect_pulse", collect_pulse, 0);
        check_value("draw_item_valid", draw_item_valid, 0);
        check_value("draw_ready", draw_ready, 1);
        check_value("load_ready", load_ready, 1);
        for (int i = 0; i < ITEM_SLOTS; i++) begin
            in_use[i] = 1'b0;
            moved[i]  = 1'b0;
        end
        foreach (loads[i]) begin
            load_item(loads[i]);
            expected_mem[loads[i].index] = loads[i].item;
            in_use[loads[i].index] = 1'b1;
        end
        item_count = 5'(loads.size());
        compare_slots();
        pulse_count = 0;
        last_angle  = angle;
        stall_on    = stalls;
        enable      = 1'b1;
        angle_track = 1'b1;
        // swing out to both bounds before the first shot
        while (angle != ANGLE_HIGH) begin
            tick();
        end
        while (angle != ANGLE_LOW) begin
            tick();
        end
        foreach (shot_angle[k]) begin
            run_shot(k);
        end
        stall_on   = 1'b0;
        draw_valid = 1'b0;
        compare_slots();
        angle_track = 1'b0;
        enable      = 1'b0;
    endtask

    initial begin
        int         fd;
        int         a;
        int         b;
        int         c;
        int         d;
        string      line;
        item_load_t ld;
        resetn     = 1'b0;
        enable     = 1'b0;
        go_key     = 1'b0;
        load_data  = '0;
        load_valid = 1'b0;
        item_count = 5'd0;
        draw_index = '0;
        draw_valid = 1'b0;
        void'($urandom(32'h2044));
        fd = $fopen("verif/rope_input.txt", "r");
        if (fd == 0) begin
            $display("stimulus file verif/rope_input.txt could not be opened");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "L %d %d %d %d", a, b, c, d) == 4) begin
                ld.index        = item_idx_t'(a);
                ld.item.x       = 9'(b);
                ld.item.y       = 8'(c);
                ld.item.kind    = item_kind_t'(d);
                ld.item.visible = 1'b1;
                ld.item.dragged = 1'b0;
                loads.push_back(ld);
            end else if ($sscanf(line, "S %d %d %d", a, b, c) == 3) begin
                shot_angle.push_back(a);
                shot_slot.push_back(b);
                shot_score.push_back(c);
            end
        end
        $fclose(fd);
        cycle_limit = 2 * 2 * (shot_angle.size() * SHOT_CYCLES + 300 * FRAME_TICKS + 500);
        run_pass(1'b0);
        run_pass(1'b1);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/rope_input.txt
# L slot x y kind      item load, kind 0 stone 1 gold 2 diamond
# S angle slot score   shot pressed at angle, hit slot (99 for none), score after
L 0 152 150 1
L 1 225 175 2
L 2 20 222 0
S 90 0 2
S 60 1 7
S 120 99 7
S 127 2 8

// File: project.f
logic/miner_pkg.sv
logic/geom_pkg.sv
logic/go_key_pulse.sv
logic/trig_rom.sv
logic/item_store.sv
logic/rope_swing_ctrl.sv
logic/score_tally.sv
logic/miner_rope_top.sv
verif/rope_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the rope testbench with Verilator, from the project root

verilator --binary --timing -f project.f --top-module rope_tb -o rope_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/rope_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
